// ==== src.f ====
+incdir+logic
logic/lv_pkg.sv
logic/lv_lbist.sv
logic/lv_scan_chk.sv
logic/lv_reg_arb.sv
logic/lv_scan_reg_bank.sv
logic/lv_owt_tx.sv
logic/lv_bist_top.sv
verif/lv_bist_assertions.sv
verif/lv_bist_tb.sv

// ==== Bender.yml ====
package:
  name: lv_bist

sources:
  - include_dirs:
      - logic
    files:
      - logic/lv_pkg.sv
      - logic/lv_lbist.sv
      - logic/lv_scan_chk.sv
      - logic/lv_reg_arb.sv
      - logic/lv_scan_reg_bank.sv
      - logic/lv_owt_tx.sv
      - logic/lv_bist_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/lv_bist_assertions.sv
      - verif/lv_bist_tb.sv

// ==== verif/lv_bist_tb.sv ====
/*
 * testbench of the low-voltage BIST
 * clock and reset, LFSR stimulus, watchdog emulation on the one-wire line,
 * register and parity model with expected verdict, checks and timeout
 */
`include "lv_macros.svh"

module lv_bist_tb import lv_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TMO       = `LV_BIST_TMO_CYC;
    localparam int CYC_LIMIT = 12 * `LV_BIST_TMO_CYC + 2000;

    logic     i_clk = 1'b0;
    logic     i_rst_n;
    logic     i_bist_en;
    logic     i_host_we;
    logic     i_host_re;
    lv_addr_t i_host_addr;
    lv_reg_t  i_host_wdata;
    logic     i_host_flip_par;
    lv_reg_t  o_host_rdata;
    logic     o_host_rvalid;
    logic     o_host_par_err;
    logic     o_owt;
    logic     i_owt_rx;
    logic     o_lv_bist_fail;

    // reference model of the bank and the verdict
    lv_reg_t     model_data  [`LV_SCAN_REG_NUM];
    logic        model_fault [`LV_SCAN_REG_NUM];
    logic [3:0]  model_seq = '0;
    logic        exp_fail;
    logic        rd_pend;
    lv_reg_t     exp_rdata;
    logic        exp_perr;
    int          bist_cyc;

    // watchdog answers, one bit per frame of a self test
    logic [3:0]  refuse_mask;
    int          frame_cnt = 0;
    int          test_base;

    logic [15:0] lfsr;
    int          cyc_total = 0;
    int          checks;
    int          errors;

    lv_bist_top i_lv_bist_top (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_bist_en       (i_bist_en),
        .i_host_we       (i_host_we),
        .i_host_re       (i_host_re),
        .i_host_addr     (i_host_addr),
        .i_host_wdata    (i_host_wdata),
        .i_host_flip_par (i_host_flip_par),
        .o_host_rdata    (o_host_rdata),
        .o_host_rvalid   (o_host_rvalid),
        .o_host_par_err  (o_host_par_err),
        .o_owt           (o_owt),
        .i_owt_rx        (i_owt_rx),
        .o_lv_bist_fail  (o_lv_bist_fail)
    );

    always #2 i_clk = ~i_clk;

    // run limit
    always @(posedge i_clk) begin
        cyc_total++;
        if (cyc_total >= CYC_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYC_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ==============================
    // helpers
    // ==============================
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic compare(input string what, input logic [15:0] got,
                           input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // one clock: check what the last edge produced, then drive the next access
    task automatic bus_cycle(input logic we, input logic re, input lv_addr_t addr,
                             input lv_reg_t data, input logic flip);
        @(posedge i_clk);
        #0.5;
        if (i_bist_en) begin
            bist_cyc++;
        end
        compare("host rvalid", o_host_rvalid, rd_pend);
        if (rd_pend && o_host_rvalid) begin
            compare("host rdata", o_host_rdata, exp_rdata);
            compare("host parity error", o_host_par_err, exp_perr);
        end
        compare("bist fail", o_lv_bist_fail, i_bist_en && bist_cyc >= TMO && exp_fail);
        if (!i_bist_en) begin
            compare("idle one-wire line", o_owt, 1'b1);
        end
        i_host_we       = we;
        i_host_re       = re;
        i_host_addr     = addr;
        i_host_wdata    = data;
        i_host_flip_par = flip;
        rd_pend         = re;
        if (re) begin
            exp_rdata = model_data[addr];
            exp_perr  = model_fault[addr];
        end
        if (we) begin
            model_data[addr]  = data;
            model_fault[addr] = flip;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) bus_cycle(1'b0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic host_write(input lv_addr_t addr, input lv_reg_t data, input logic flip);
        bus_cycle(1'b1, 1'b0, addr, data, flip);
    endtask

    task automatic host_read(input lv_addr_t addr);
        bus_cycle(1'b0, 1'b1, addr, '0, 1'b0);
    endtask

    task automatic clear_faults();
        for (int i = 0; i < `LV_SCAN_REG_NUM; i++) begin
            if (model_fault[i]) begin
                host_write(lv_addr_t'(i), model_data[i], 1'b0);
            end
        end
    endtask

    // one enable window, optionally with random host traffic
    task automatic self_test(input logic [3:0] mask, input logic traffic);
        lv_addr_t a;
        lv_reg_t  d;
        logic     any_fault;
        int       ok;
        int       op;
        any_fault = 1'b0;
        for (int i = 0; i < `LV_SCAN_REG_NUM; i++) begin
            any_fault |= model_fault[i];
        end
        ok = `LV_BIST_OWT_TX_NUM;
        for (int i = 0; i < `LV_BIST_OWT_TX_NUM; i++) begin
            ok -= mask[i];
        end
        exp_fail    = any_fault || (ok < `LV_BIST_OWT_OK_NUM);
        refuse_mask = mask;
        test_base   = frame_cnt;
        bist_cyc    = 0;
        i_bist_en   = 1'b1;
        repeat (TMO + 5) begin
            a  = lv_addr_t'(rand_bits(3));
            d  = lv_reg_t'(rand_bits(8));
            op = int'(rand_bits(2));
            if (traffic && op == 0) begin
                // keep the planted fault so the verdict stays put
                host_write(a, d, model_fault[a]);
            end else if (traffic && op == 1) begin
                host_read(a);
            end else begin
                idle_cycles(1);
            end
        end
        compare("frames per self test", 16'(frame_cnt - test_base), `LV_BIST_OWT_TX_NUM);
        i_bist_en = 1'b0;
        bist_cyc  = 0;
        idle_cycles(3);
    endtask

    // ==============================
    // watchdog emulation
    // ==============================
    initial begin : watchdog
        logic [`LV_OWT_FRAME_W-1:0] frame;
        logic                       refuse;
        int                         idx;
        int                         k;
        forever begin
            @(negedge i_clk);
            // first cycle of a start bit
            if (i_rst_n === 1'b1 && o_owt === 1'b0) begin
                frame = '0;
                for (k = 0; k < `LV_OWT_FRAME_W; k++) begin
                    repeat ((k == 0) ? `LV_OWT_BIT_CYC + 1 : `LV_OWT_BIT_CYC) @(negedge i_clk);
                    frame = {frame[`LV_OWT_FRAME_W-2:0], o_owt};
                end
                compare("one-wire frame", frame, {`LV_OWT_FRAME_BASE, model_seq});
                model_seq = model_seq + 1'b1;
                idx       = frame_cnt - test_base;
                refuse    = (idx >= 0 && idx < 4) ? refuse_mask[idx] : 1'b0;
                frame_cnt++;
                // answer over the whole response bit period
                repeat (`LV_OWT_BIT_CYC - 2) @(negedge i_clk);
                @(posedge i_clk);
                #0.5;
                i_owt_rx = refuse;
                repeat (`LV_OWT_BIT_CYC) @(posedge i_clk);
                #0.5;
                i_owt_rx = 1'b1;
            end
        end
    end

    // ==============================
    // test sequence
    // ==============================
    initial begin : main
        lv_addr_t   a;
        lv_reg_t    d;
        logic       f;
        logic [3:0] mask;
        int         r;
        int         n;
        int         asrt_fails;
        i_rst_n         = 1'b0;
        i_bist_en       = 1'b0;
        i_host_we       = 1'b0;
        i_host_re       = 1'b0;
        i_host_addr     = '0;
        i_host_wdata    = '0;
        i_host_flip_par = 1'b0;
        i_owt_rx        = 1'b1;
        lfsr            = 16'd9460;
        rd_pend         = 1'b0;
        exp_fail        = 1'b0;
        bist_cyc        = 0;
        refuse_mask     = '0;
        test_base       = 0;
        checks          = 0;
        errors          = 0;
        for (int i = 0; i < `LV_SCAN_REG_NUM; i++) begin
            model_data[i]  = '0;
            model_fault[i] = 1'b0;
        end

        // outputs sit inactive through reset
        idle_cycles(10);
        i_rst_n = 1'b1;
        idle_cycles(2);

        // host writes and reads, some with planted faults
        for (int i = 0; i < `LV_SCAN_REG_NUM; i++) begin
            d = lv_reg_t'(rand_bits(8));
            host_write(lv_addr_t'(i), d, 1'b0);
        end
        for (int i = 0; i < `LV_SCAN_REG_NUM; i++) begin
            host_read(lv_addr_t'(i));
        end
        repeat (24) begin
            a = lv_addr_t'(rand_bits(3));
            d = lv_reg_t'(rand_bits(8));
            f = (rand_bits(2) == 0);
            if (rand_bits(1) != 0) begin
                host_write(a, d, f);
            end else begin
                host_read(a);
            end
        end
        for (int i = 0; i < `LV_SCAN_REG_NUM; i++) begin
            host_read(lv_addr_t'(i));
        end
        clear_faults();

        // clean bank, at most one refusal
        r = int'(rand_bits(3));
        self_test((r < 4) ? 4'(1 << r) : 4'h0, 1'b0);

        // planted parity faults
        n = 1 + int'(rand_bits(1));
        repeat (n) begin
            a = lv_addr_t'(rand_bits(3));
            d = lv_reg_t'(rand_bits(8));
            host_write(a, d, 1'b1);
        end
        self_test(4'h0, 1'b0);
        clear_faults();

        // two or more refusals
        r    = int'(rand_bits(2));
        n    = (r + 1 + int'(rand_bits(1))) % 4;
        mask = 4'(1 << r) | 4'(1 << n) | 4'(rand_bits(4));
        self_test(mask, 1'b0);

        // host traffic inside the enable window
        repeat (6) begin
            for (int i = 0; i < `LV_SCAN_REG_NUM; i++) begin
                if (rand_bits(3) == 0) begin
                    d = lv_reg_t'(rand_bits(8));
                    host_write(lv_addr_t'(i), d, 1'b1);
                end
            end
            mask = 4'(rand_bits(4));
            self_test(mask, 1'b1);
            clear_faults();
        end
        idle_cycles(2);

        asrt_fails = int'(i_lv_bist_top.i_lv_lbist.i_seq_asrt.fail_cnt)
                   + int'(i_lv_bist_top.i_lv_reg_arb.i_arb_asrt.fail_cnt);
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/lv_bist_assertions.sv ====
/*
 * concurrent assertions on the BIST sequencer and the bank arbiter
 * attached to lv_lbist and lv_reg_arb
 */
module lv_bist_assertions (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_bist_en,
    input logic i_scan_req,
    input logic i_scan_ack,
    input logic i_tx_req,
    input logic i_tx_ack,
    input logic i_fail,
    input logic i_host_acc,
    input logic i_chk_gnt
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;

    // acks only answer a raised request
    scan_ack_in_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_scan_ack |-> i_scan_req)
        else begin
            fail_cnt++;
            $error("scan ack seen while the scan request is low");
        end

    owt_ack_in_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_tx_ack |-> i_tx_req)
        else begin
            fail_cnt++;
            $error("one-wire ack seen while the transmit request is low");
        end

    // host always wins the bank
    host_first: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_host_acc |-> !i_chk_gnt)
        else begin
            fail_cnt++;
            $error("checker granted during a host access");
        end

    // verdict is registered, so it follows enable one cycle later
    no_fail_when_off: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_bist_en |=> !i_fail)
        else begin
            fail_cnt++;
            $error("self-test fail high while enable is low");
        end

endmodule

// sequencer handshakes and verdict
bind lv_lbist lv_bist_assertions i_seq_asrt (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_bist_en  (i_bist_en),
    .i_scan_req (o_bist_scan_reg_req),
    .i_scan_ack (i_scan_reg_bist_ack),
    .i_tx_req   (o_bist_wdg_owt_tx_req),
    .i_tx_ack   (i_owt_rx_ack),
    .i_fail     (o_lv_bist_fail),
    .i_host_acc (1'b0),
    .i_chk_gnt  (1'b0)
);

// bank port priority
bind lv_reg_arb lv_bist_assertions i_arb_asrt (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_bist_en  (1'b1),
    .i_scan_req (1'b0),
    .i_scan_ack (1'b0),
    .i_tx_req   (1'b0),
    .i_tx_ack   (1'b0),
    .i_fail     (1'b0),
    .i_host_acc (i_host_we | i_host_re),
    .i_chk_gnt  (o_chk_gnt)
);

// ==== logic/lv_bist_top.sv ====
/*
 * low-voltage BIST top level
 * sequencer, scan checker, arbiter, register bank, one-wire transmitter
 */
module lv_bist_top import lv_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_bist_en,
    input  logic     i_host_we,
    input  logic     i_host_re,
    input  lv_addr_t i_host_addr,
    input  lv_reg_t  i_host_wdata,
    input  logic     i_host_flip_par,
    output lv_reg_t  o_host_rdata,
    output logic     o_host_rvalid,
    output logic     o_host_par_err,
    output logic     o_owt,
    input  logic     i_owt_rx,
    output logic     o_lv_bist_fail
);

    logic     bist_scan_req;
    logic     scan_ack;
    logic     scan_err;
    logic     owt_tx_req;
    logic     owt_rx_ack;
    logic     owt_rx_status;
    logic     chk_re;
    lv_addr_t chk_addr;
    logic     chk_gnt;
    logic     chk_rvalid;
    logic     bank_we;
    logic     bank_re;
    lv_addr_t bank_addr;
    lv_reg_t  bank_wdata;
    logic     bank_flip_par;
    logic     bank_rvalid;

    lv_lbist i_lv_lbist (
        .i_clk                 (i_clk),
        .i_rst_n               (i_rst_n),
        .i_bist_en             (i_bist_en),
        .o_bist_scan_reg_req   (bist_scan_req),
        .i_scan_reg_bist_ack   (scan_ack),
        .i_scan_reg_bist_err   (scan_err),
        .o_bist_wdg_owt_tx_req (owt_tx_req),
        .i_owt_rx_ack          (owt_rx_ack),
        .i_owt_rx_status       (owt_rx_status),
        .o_lv_bist_fail        (o_lv_bist_fail)
    );

    // parity error is shared by host and checker
    lv_scan_chk i_lv_scan_chk (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_bist_en    (i_bist_en),
        .i_scan_req   (bist_scan_req),
        .o_scan_ack   (scan_ack),
        .o_scan_err   (scan_err),
        .o_chk_re     (chk_re),
        .o_chk_addr   (chk_addr),
        .i_chk_gnt    (chk_gnt),
        .i_rd_par_err (o_host_par_err),
        .i_rd_valid   (chk_rvalid)
    );

    lv_reg_arb i_lv_reg_arb (
        .i_host_we       (i_host_we),
        .i_host_re       (i_host_re),
        .i_host_addr     (i_host_addr),
        .i_host_wdata    (i_host_wdata),
        .i_host_flip_par (i_host_flip_par),
        .i_chk_re        (chk_re),
        .i_chk_addr      (chk_addr),
        .o_chk_gnt       (chk_gnt),
        .o_bank_we       (bank_we),
        .o_bank_re       (bank_re),
        .o_bank_addr     (bank_addr),
        .o_bank_wdata    (bank_wdata),
        .o_bank_flip_par (bank_flip_par),
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_bank_rvalid   (bank_rvalid),
        .o_host_rvalid   (o_host_rvalid),
        .o_chk_rvalid    (chk_rvalid)
    );

    lv_scan_reg_bank i_lv_scan_reg_bank (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_we       (bank_we),
        .i_re       (bank_re),
        .i_addr     (bank_addr),
        .i_wdata    (bank_wdata),
        .i_flip_par (bank_flip_par),
        .o_rdata    (o_host_rdata),
        .o_rvalid   (bank_rvalid),
        .o_par_err  (o_host_par_err)
    );

    lv_owt_tx i_lv_owt_tx (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_tx_req    (owt_tx_req),
        .o_owt       (o_owt),
        .i_owt_rx    (i_owt_rx),
        .o_rx_ack    (owt_rx_ack),
        .o_rx_status (owt_rx_status)
    );

endmodule

// ==== logic/lv_owt_tx.sv ====
/*
 * one-wire frame transmitter
 * start bit plus base/sequence frame, MSB first,
 * then one response bit period sampled at its last cycle
 */
`include "lv_macros.svh"

module lv_owt_tx import lv_pkg::*; (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_tx_req,
    output logic o_owt,
    input  logic i_owt_rx,
    output logic o_rx_ack,
    output logic o_rx_status
);

    localparam int SEQ_W   = `LV_OWT_FRAME_W - 4;
    localparam int CYC_W   = $clog2(`LV_OWT_BIT_CYC);
    localparam int BIT_W   = $clog2(`LV_OWT_FRAME_W + 1);
    localparam int LAST_CYC = `LV_OWT_BIT_CYC - 1;

    owt_state_e                state;
    logic [CYC_W-1:0]          cyc_cnt;
    logic [BIT_W-1:0]          bit_cnt;
    // start bit on top of the frame
    logic [`LV_OWT_FRAME_W:0]  shreg;
    logic [SEQ_W-1:0]          seq_num;
    logic                      bit_end;

    assign bit_end = (cyc_cnt == CYC_W'(LAST_CYC));
    // line released high outside the frame
    assign o_owt   = (state == OWT_FRAME) ? shreg[`LV_OWT_FRAME_W] : 1'b1;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= OWT_IDLE;
            cyc_cnt     <= '0;
            bit_cnt     <= '0;
            shreg       <= '1;
            seq_num     <= '0;
            o_rx_ack    <= 1'b0;
            o_rx_status <= 1'b0;
        end else begin
            o_rx_ack <= 1'b0;
            case (state)
                OWT_IDLE: begin
                    // request is still high during the ack cycle
                    if (i_tx_req && !o_rx_ack) begin
                        state   <= OWT_FRAME;
                        cyc_cnt <= '0;
                        bit_cnt <= '0;
                        shreg   <= {1'b0, `LV_OWT_FRAME_BASE, seq_num};
                    end
                end
                OWT_FRAME: begin
                    cyc_cnt <= cyc_cnt + 1'b1;
                    if (bit_end) begin
                        cyc_cnt <= '0;
                        shreg   <= {shreg[`LV_OWT_FRAME_W-1:0], 1'b1};
                        if (bit_cnt == BIT_W'(`LV_OWT_FRAME_W)) begin
                            state <= OWT_RESP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                OWT_RESP: begin
                    cyc_cnt <= cyc_cnt + 1'b1;
                    if (bit_end) begin
                        // high here is a refusal
                        o_rx_status <= i_owt_rx;
                        o_rx_ack    <= 1'b1;
                        seq_num     <= seq_num + 1'b1;
                        cyc_cnt     <= '0;
                        state       <= OWT_IDLE;
                    end
                end
                default: begin
                    state <= OWT_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/lv_scan_reg_bank.sv ====
/*
 * parity-protected configuration register bank
 * single port, one-cycle read with parity check,
 * write with optional inverted parity for fault injection
 */
`include "lv_macros.svh"

module lv_scan_reg_bank import lv_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_we,
    input  logic     i_re,
    input  lv_addr_t i_addr,
    input  lv_reg_t  i_wdata,
    input  logic     i_flip_par,
    output lv_reg_t  o_rdata,
    output logic     o_rvalid,
    output logic     o_par_err
);

    lv_reg_t regs [`LV_SCAN_REG_NUM];
    logic    par  [`LV_SCAN_REG_NUM];

    // ==============================
    // storage
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            // zero data, even parity
            for (int i = 0; i < `LV_SCAN_REG_NUM; i++) begin
                regs[i] <= '0;
                par[i]  <= 1'b0;
            end
        end else if (i_we) begin
            regs[i_addr] <= i_wdata;
            par[i_addr]  <= (^i_wdata) ^ i_flip_par;
        end
    end

    // ==============================
    // read port
    // ==============================
    always_ff @(posedge i_clk) begin
        if (i_re) begin
            o_rdata   <= regs[i_addr];
            o_par_err <= (^regs[i_addr]) ^ par[i_addr];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rvalid <= 1'b0;
        end else begin
            o_rvalid <= i_re;
        end
    end

endmodule

// ==== logic/lv_reg_arb.sv ====
/*
 * bank port arbiter
 * fixed priority with the host first, read owner tracking
 * for return of the bank read-valid
 */
module lv_reg_arb import lv_pkg::*; (
    input  logic     i_host_we,
    input  logic     i_host_re,
    input  lv_addr_t i_host_addr,
    input  lv_reg_t  i_host_wdata,
    input  logic     i_host_flip_par,
    input  logic     i_chk_re,
    input  lv_addr_t i_chk_addr,
    output logic     o_chk_gnt,
    output logic     o_bank_we,
    output logic     o_bank_re,
    output lv_addr_t o_bank_addr,
    output lv_reg_t  o_bank_wdata,
    output logic     o_bank_flip_par,
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_bank_rvalid,
    output logic     o_host_rvalid,
    output logic     o_chk_rvalid
);

    logic host_acc;
    logic rd_owner_chk;

    assign host_acc        = i_host_we | i_host_re;
    assign o_chk_gnt       = i_chk_re & ~host_acc;

    assign o_bank_we       = i_host_we;
    assign o_bank_re       = i_host_re | o_chk_gnt;
    assign o_bank_addr     = host_acc ? i_host_addr : i_chk_addr;
    assign o_bank_wdata    = i_host_wdata;
    assign o_bank_flip_par = i_host_flip_par & i_host_we;

    // who issued the read now returning
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_owner_chk <= 1'b0;
        end else begin
            rd_owner_chk <= o_chk_gnt;
        end
    end

    assign o_host_rvalid = i_bank_rvalid & ~rd_owner_chk;
    assign o_chk_rvalid  = i_bank_rvalid & rd_owner_chk;

endmodule

// ==== logic/lv_scan_chk.sv ====
/*
 * scan checker
 * walks the bank indexes, one read per scan request,
 * answers with an ack pulse and the parity error of that register
 */
module lv_scan_chk import lv_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_bist_en,
    input  logic     i_scan_req,
    output logic     o_scan_ack,
    output logic     o_scan_err,
    output logic     o_chk_re,
    output lv_addr_t o_chk_addr,
    input  logic     i_chk_gnt,
    input  logic     i_rd_par_err,
    input  logic     i_rd_valid
);

    lv_addr_t idx;
    // a check is in flight from request accept to ack
    logic     busy;

    assign o_chk_addr = idx;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idx        <= '0;
            busy       <= 1'b0;
            o_chk_re   <= 1'b0;
            o_scan_ack <= 1'b0;
            o_scan_err <= 1'b0;
        end else if (!i_bist_en) begin
            idx        <= '0;
            busy       <= 1'b0;
            o_chk_re   <= 1'b0;
            o_scan_ack <= 1'b0;
            o_scan_err <= 1'b0;
        end else begin
            o_scan_ack <= i_rd_valid & busy;
            o_scan_err <= i_rd_valid & busy & i_rd_par_err;
            if (o_scan_ack) begin
                busy <= 1'b0;
            end else if (i_scan_req && !busy) begin
                busy     <= 1'b1;
                o_chk_re <= 1'b1;
            end
            // hold the read until the arbiter lets it through
            if (o_chk_re && i_chk_gnt) begin
                o_chk_re <= 1'b0;
            end
            if (i_rd_valid && busy) begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

// ==== logic/lv_lbist.sv ====
/*
 * self-test sequencer
 * scan and one-wire request levels, ack counters,
 * scan error latch, timeout counter and pass/fail verdict
 */
`include "lv_macros.svh"

module lv_lbist import lv_pkg::*; (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_bist_en,
    output logic o_bist_scan_reg_req,
    input  logic i_scan_reg_bist_ack,
    input  logic i_scan_reg_bist_err,
    output logic o_bist_wdg_owt_tx_req,
    input  logic i_owt_rx_ack,
    input  logic i_owt_rx_status,
    output logic o_lv_bist_fail
);

    localparam int SCAN_CNT_W = $clog2(`LV_SCAN_REG_NUM + 1);
    localparam int TX_CNT_W   = $clog2(`LV_BIST_OWT_TX_NUM + 1);
    localparam int TMO_CNT_W  = $clog2(`LV_BIST_TMO_CYC);

    logic [SCAN_CNT_W-1:0] scan_cnt;
    logic                  scan_err_seen;
    logic [TX_CNT_W-1:0]   owt_tx_cnt;
    logic [TX_CNT_W-1:0]   owt_ok_cnt;
    logic [TMO_CNT_W-1:0]  tmo_cnt;
    logic                  tmo_sat;
    logic                  fail_rule;

    assign tmo_sat   = (tmo_cnt == TMO_CNT_W'(`LV_BIST_TMO_CYC - 1));
    assign fail_rule = scan_err_seen | (owt_ok_cnt < TX_CNT_W'(`LV_BIST_OWT_OK_NUM));

    // ==============================
    // scan checks
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scan_cnt      <= '0;
            scan_err_seen <= 1'b0;
        end else if (!i_bist_en) begin
            scan_cnt      <= '0;
            scan_err_seen <= 1'b0;
        end else if (i_scan_reg_bist_ack) begin
            if (scan_cnt != SCAN_CNT_W'(`LV_SCAN_REG_NUM)) begin
                scan_cnt <= scan_cnt + 1'b1;
            end
            if (i_scan_reg_bist_err) begin
                scan_err_seen <= 1'b1;
            end
        end
    end

    // drops for one cycle after each ack
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_bist_scan_reg_req <= 1'b0;
        end else if (i_scan_reg_bist_ack) begin
            o_bist_scan_reg_req <= 1'b0;
        end else begin
            o_bist_scan_reg_req <= i_bist_en &&
                                   (scan_cnt < SCAN_CNT_W'(`LV_SCAN_REG_NUM));
        end
    end

    // ==============================
    // one-wire frames
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            owt_tx_cnt <= '0;
            owt_ok_cnt <= '0;
        end else if (!i_bist_en) begin
            owt_tx_cnt <= '0;
            owt_ok_cnt <= '0;
        end else if (i_owt_rx_ack) begin
            if (owt_tx_cnt != TX_CNT_W'(`LV_BIST_OWT_TX_NUM)) begin
                owt_tx_cnt <= owt_tx_cnt + 1'b1;
            end
            // status 0 means the watchdog took the frame
            if (!i_owt_rx_status && owt_ok_cnt != TX_CNT_W'(`LV_BIST_OWT_TX_NUM)) begin
                owt_ok_cnt <= owt_ok_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_bist_wdg_owt_tx_req <= 1'b0;
        end else if (i_owt_rx_ack) begin
            o_bist_wdg_owt_tx_req <= 1'b0;
        end else begin
            o_bist_wdg_owt_tx_req <= i_bist_en &&
                                     (owt_tx_cnt < TX_CNT_W'(`LV_BIST_OWT_TX_NUM));
        end
    end

    // ==============================
    // timeout and verdict
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tmo_cnt <= '0;
        end else if (!i_bist_en) begin
            tmo_cnt <= '0;
        end else if (!tmo_sat) begin
            tmo_cnt <= tmo_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_lv_bist_fail <= 1'b0;
        end else begin
            o_lv_bist_fail <= i_bist_en & tmo_sat & fail_rule;
        end
    end

endmodule

// ==== logic/lv_pkg.sv ====
/*
 * shared types of the low-voltage BIST
 * register word, register index, one-wire transmitter states
 */
`include "lv_macros.svh"

package lv_pkg;

    // one bank word
    typedef logic [`LV_REG_W-1:0] lv_reg_t;

    // bank index
    typedef logic [$clog2(`LV_SCAN_REG_NUM)-1:0] lv_addr_t;

    typedef enum logic [1:0] {
        OWT_IDLE,
        OWT_FRAME,
        OWT_RESP
    } owt_state_e;

endpackage

// ==== logic/lv_macros.svh ====
/*
 * size, count and timing constants of the low-voltage BIST
 * bank geometry, one-wire frame format, pass threshold, timeout window
 */
`ifndef LV_MACROS_SVH
`define LV_MACROS_SVH

// register bank
`define LV_SCAN_REG_NUM     8
`define LV_REG_W            8

// one-wire link
`define LV_OWT_BIT_CYC      4
`define LV_OWT_FRAME_W      8
`define LV_OWT_FRAME_BASE   4'hA

// self-test sequencing
`define LV_BIST_OWT_TX_NUM  4
`define LV_BIST_OWT_OK_NUM  3
`define LV_BIST_TMO_CYC     400

`endif
